//--- rtl/cpu_pkg.sv
package cpu_pkg;

typedef logic [31:0] uint32_t;
typedef logic [4:0]  reg_addr_t;

// Tag width caps ROB_DEPTH at 16
localparam int ROB_IDX_W = 4;
typedef logic [ROB_IDX_W-1:0] rob_index_t;

typedef struct packed {
	logic [5:0] opcode;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd;
	logic [4:0] shamt;
	logic [5:0] funct;
} r_fields_t;

typedef struct packed {
	logic [5:0]  opcode;
	reg_addr_t   rs;
	reg_addr_t   rt;
	logic [15:0] imm16;
} i_fields_t;

typedef union packed {
	r_fields_t r_fields;
	i_fields_t i_fields;
} instr_t;

typedef enum logic [3:0] {
	OP_ADDU,
	OP_SUBU,
	OP_AND,
	OP_OR,
	OP_XOR,
	OP_SLT,
	OP_ADDIU,
	OP_ORI,
	OP_LUI
} alu_op_t;

typedef struct packed {
	logic       ready;
	rob_index_t tag;
	uint32_t    value;
} operand_t;

typedef struct packed {
	logic       busy;
	rob_index_t reorder;
} register_status_t;

typedef struct packed {
	alu_op_t    op;
	operand_t   op1;
	operand_t   op2;
	rob_index_t dest;
} rs_entry_t;

typedef struct packed {
	logic      has_dest;
	reg_addr_t dest;
} rob_packet_t;

typedef struct packed {
	logic       valid;
	rob_index_t tag;
	uint32_t    value;
} cdb_packet_t;

typedef struct packed {
	logic      valid;
	reg_addr_t dest;
	uint32_t   value;
} commit_t;

endpackage

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            we,
	input  reg_addr_t       waddr,
	input  uint32_t         wdata,
	input  reg_addr_t [3:0] raddr,
	output uint32_t   [3:0] rdata
);

uint32_t [31:0] regs;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		regs <= '0;
	end else if (we && waddr != '0) begin
		regs[waddr] <= wdata;
	end
end

// Write-first so a commit and a read in one cycle agree
always_comb begin
	for (int p = 0; p < 4; p++) begin
		if (raddr[p] == '0) begin
			rdata[p] = '0;
		end else if (we && waddr == raddr[p]) begin
			rdata[p] = wdata;
		end else begin
			rdata[p] = regs[raddr[p]];
		end
	end
end

endmodule

//--- rtl/regfile_status.sv
`timescale 1ns/1ps

module regfile_status import cpu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   we,
	input  reg_addr_t              waddr,
	input  register_status_t       wdata,
	input  logic                   wrst,
	input  rob_index_t             wreorder,
	input  reg_addr_t        [3:0] raddr,
	output register_status_t [3:0] rdata
);

register_status_t [31:0] status;

// r0 is never touched, so it stays idle after reset
always_ff @(posedge clk) begin
	if (!rst_n) begin
		status <= '0;
	end else begin
		for (int i = 1; i < 32; i++) begin
			if (we && waddr == reg_addr_t'(i)) begin
				status[i] <= wdata;
			end else if (wrst && status[i].busy && status[i].reorder == wreorder) begin
				// Only the newest producer may free the register
				status[i].busy <= 1'b0;
			end
		end
	end
end

always_comb begin
	for (int p = 0; p < 4; p++) begin
		rdata[p] = status[raddr[p]];
	end
end

endmodule

//--- rtl/rob.sv
`timescale 1ns/1ps

module rob import cpu_pkg::*; #(
	parameter int ROB_DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push,
	input  rob_packet_t      data_i,
	output rob_index_t       reorder,
	output logic             full,
	input  logic             pop,
	output logic             head_valid,
	output logic             head_done,
	output rob_index_t       head_tag,
	output rob_packet_t      data_o,
	output uint32_t          head_value,
	input  cdb_packet_t      cdb,
	input  rob_index_t [1:0] rob_raddr,
	output logic       [1:0] rob_rdata_valid,
	output uint32_t    [1:0] rob_rdata
);

localparam int PTR_W = $clog2(ROB_DEPTH);

rob_packet_t          packets [ROB_DEPTH];
uint32_t              values  [ROB_DEPTH];
logic [ROB_DEPTH-1:0] done;
logic [PTR_W-1:0]     head;
logic [PTR_W-1:0]     tail;
logic [PTR_W:0]       count;
logic [PTR_W-1:0]     cdb_ptr;

assign cdb_ptr = cdb.tag[PTR_W-1:0];

always_ff @(posedge clk) begin
	if (!rst_n) begin
		head  <= '0;
		tail  <= '0;
		count <= '0;
	end else begin
		if (push) begin
			tail <= tail + 1'b1;
		end
		if (pop) begin
			head <= head + 1'b1;
		end
		case ({push, pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		done <= '0;
	end else begin
		if (push) begin
			done[tail] <= 1'b0;
		end
		if (cdb.valid) begin
			done[cdb_ptr] <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (push) begin
		packets[tail] <= data_i;
	end
	if (cdb.valid) begin
		values[cdb_ptr] <= cdb.value;
	end
end

assign reorder    = rob_index_t'(tail);
assign full       = (count == (PTR_W + 1)'(ROB_DEPTH));
assign head_valid = (count != '0);
assign head_done  = done[head];
assign head_tag   = rob_index_t'(head);
assign data_o     = packets[head];
assign head_value = values[head];

// Operand lookup by ROB tag
for (genvar i = 0; i < 2; i++) begin : g_lookup
	logic [PTR_W-1:0] ptr;

	assign ptr                = rob_raddr[i][PTR_W-1:0];
	assign rob_rdata_valid[i] = done[ptr];
	assign rob_rdata[i]       = values[ptr];
end

endmodule

//--- rtl/instr_issue.sv
`timescale 1ns/1ps

module instr_issue import cpu_pkg::*; (
	input  logic                   instr_valid,
	input  instr_t                 instr,
	output logic                   instr_ready,
	input  logic                   rob_full,
	input  rob_index_t             rob_reorder,
	output logic                   rob_push,
	output rob_packet_t            rob_push_data,
	input  logic                   rs_full,
	output logic                   rs_push,
	output rs_entry_t              rs_in,
	output reg_addr_t        [3:0] reg_raddr,
	input  uint32_t          [3:0] reg_rdata,
	input  register_status_t [3:0] reg_status,
	output logic                   status_we,
	output reg_addr_t              status_waddr,
	output register_status_t       status_wdata,
	output rob_index_t       [1:0] rob_raddr,
	input  logic             [1:0] rob_rdata_valid,
	input  uint32_t          [1:0] rob_rdata,
	input  cdb_packet_t            cdb
);

alu_op_t   op;
reg_addr_t src1;
reg_addr_t src2;
reg_addr_t dest;
uint32_t   imm;
logic      use_imm;
logic      fire;

function automatic operand_t pick_operand(register_status_t st, uint32_t rf_val,
		logic rob_hit, uint32_t rob_val, cdb_packet_t bus);
	operand_t o;
	o.ready = 1'b1;
	o.tag   = st.reorder;
	o.value = rf_val;
	if (st.busy) begin
		if (rob_hit) begin
			o.value = rob_val;
		end else if (bus.valid && bus.tag == st.reorder) begin
			o.value = bus.value;
		end else begin
			o.ready = 1'b0;
			o.value = '0;
		end
	end
	return o;
endfunction

always_comb begin
	op      = OP_ADDU;
	src1    = instr.r_fields.rs;
	src2    = instr.r_fields.rt;
	dest    = instr.r_fields.rd;
	imm     = '0;
	use_imm = 1'b0;
	case (instr.r_fields.opcode)
		6'h00: begin
			case (instr.r_fields.funct)
				6'h21:   op = OP_ADDU;
				6'h23:   op = OP_SUBU;
				6'h24:   op = OP_AND;
				6'h25:   op = OP_OR;
				6'h26:   op = OP_XOR;
				6'h2a:   op = OP_SLT;
				default: begin
					src1 = '0;
					src2 = '0;
					dest = '0;
				end
			endcase
		end
		6'h09: begin
			op      = OP_ADDIU;
			src1    = instr.i_fields.rs;
			dest    = instr.i_fields.rt;
			use_imm = 1'b1;
			imm     = {{16{instr.i_fields.imm16[15]}}, instr.i_fields.imm16};
		end
		6'h0d: begin
			op      = OP_ORI;
			src1    = instr.i_fields.rs;
			dest    = instr.i_fields.rt;
			use_imm = 1'b1;
			imm     = {16'h0, instr.i_fields.imm16};
		end
		6'h0f: begin
			op      = OP_LUI;
			src1    = '0;
			dest    = instr.i_fields.rt;
			use_imm = 1'b1;
			imm     = {instr.i_fields.imm16, 16'h0};
		end
		// Unknown opcodes become a harmless ADDU into r0
		default: begin
			src1 = '0;
			src2 = '0;
			dest = '0;
		end
	endcase
end

assign reg_raddr = {5'd0, 5'd0, src2, src1};
assign rob_raddr = {reg_status[1].reorder, reg_status[0].reorder};

assign instr_ready = !rob_full && !rs_full;
assign fire        = instr_valid && instr_ready;

assign rob_push      = fire;
assign rob_push_data = '{has_dest: dest != '0, dest: dest};

assign status_we    = fire && dest != '0;
assign status_waddr = dest;
assign status_wdata = '{busy: 1'b1, reorder: rob_reorder};

assign rs_push   = fire;
assign rs_in.op  = op;
assign rs_in.op1 = pick_operand(reg_status[0], reg_rdata[0], rob_rdata_valid[0],
	rob_rdata[0], cdb);
assign rs_in.op2 = use_imm ? operand_t'{ready: 1'b1, tag: '0, value: imm}
	: pick_operand(reg_status[1], reg_rdata[1], rob_rdata_valid[1], rob_rdata[1], cdb);
assign rs_in.dest = rob_reorder;

endmodule

//--- rtl/alu_exec.sv
`timescale 1ns/1ps

module alu_exec import cpu_pkg::*; #(
	parameter int RS_DEPTH = 4
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rs_push,
	input  rs_entry_t   rs_in,
	output logic        rs_full,
	output cdb_packet_t cdb
);

localparam int IDX_W = $clog2(RS_DEPTH);

rs_entry_t           entries [RS_DEPTH];
logic [RS_DEPTH-1:0] valid;
// Age counts the younger entries still waiting
logic [IDX_W-1:0]    age [RS_DEPTH];
logic [IDX_W-1:0]    free_idx;
logic                sel_valid;
logic [IDX_W-1:0]    sel_idx;
logic [IDX_W-1:0]    sel_age;
rs_entry_t           sel;
uint32_t             result;

assign rs_full = &valid;

always_comb begin
	free_idx = '0;
	for (int i = RS_DEPTH - 1; i >= 0; i--) begin
		if (!valid[i]) begin
			free_idx = IDX_W'(i);
		end
	end
end

// Oldest entry with both operands ready
always_comb begin
	sel_valid = 1'b0;
	sel_idx   = '0;
	sel_age   = '0;
	for (int i = 0; i < RS_DEPTH; i++) begin
		if (valid[i] && entries[i].op1.ready && entries[i].op2.ready &&
				(!sel_valid || age[i] > sel_age)) begin
			sel_valid = 1'b1;
			sel_idx   = IDX_W'(i);
			sel_age   = age[i];
		end
	end
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		valid <= '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			age[i] <= '0;
		end
	end else begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (rs_push && free_idx == IDX_W'(i)) begin
				valid[i] <= 1'b1;
				age[i]   <= '0;
			end else if (valid[i]) begin
				if (sel_valid && sel_idx == IDX_W'(i)) begin
					valid[i] <= 1'b0;
				end else begin
					age[i] <= age[i] + IDX_W'(rs_push) - IDX_W'(sel_valid && age[i] > sel_age);
				end
			end
		end
	end
end

// Operand wakeup from the CDB
always_ff @(posedge clk) begin
	for (int i = 0; i < RS_DEPTH; i++) begin
		if (rs_push && free_idx == IDX_W'(i)) begin
			entries[i] <= rs_in;
		end else if (cdb.valid) begin
			if (!entries[i].op1.ready && entries[i].op1.tag == cdb.tag) begin
				entries[i].op1.ready <= 1'b1;
				entries[i].op1.value <= cdb.value;
			end
			if (!entries[i].op2.ready && entries[i].op2.tag == cdb.tag) begin
				entries[i].op2.ready <= 1'b1;
				entries[i].op2.value <= cdb.value;
			end
		end
	end
end

assign sel = entries[sel_idx];

always_comb begin
	case (sel.op)
		OP_ADDU, OP_ADDIU: result = sel.op1.value + sel.op2.value;
		OP_SUBU:           result = sel.op1.value - sel.op2.value;
		OP_AND:            result = sel.op1.value & sel.op2.value;
		OP_OR, OP_ORI:     result = sel.op1.value | sel.op2.value;
		OP_XOR:            result = sel.op1.value ^ sel.op2.value;
		OP_SLT:            result = {31'b0, $signed(sel.op1.value) < $signed(sel.op2.value)};
		OP_LUI:            result = sel.op2.value;
		default:           result = '0;
	endcase
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		cdb.valid <= 1'b0;
	end else begin
		cdb.valid <= sel_valid;
	end
	cdb.tag   <= sel.dest;
	cdb.value <= result;
end

endmodule

//--- rtl/instr_commit.sv
`timescale 1ns/1ps

module instr_commit import cpu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rob_head_valid,
	input  logic        rob_head_done,
	input  rob_index_t  rob_head_tag,
	input  rob_packet_t rob_pop_data,
	input  uint32_t     rob_head_value,
	output logic        rob_pop,
	output logic        reg_we,
	output reg_addr_t   reg_waddr,
	output uint32_t     reg_wdata,
	output logic        commit_wrst,
	output rob_index_t  commit_tag,
	output commit_t     commit
);

// Retire in order, at most one per cycle
assign rob_pop = rob_head_valid && rob_head_done;

assign reg_we      = rob_pop && rob_pop_data.has_dest;
assign reg_waddr   = rob_pop_data.dest;
assign reg_wdata   = rob_head_value;
assign commit_wrst = rob_pop;
assign commit_tag  = rob_head_tag;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		commit.valid <= 1'b0;
	end else begin
		commit.valid <= rob_pop;
	end
	commit.dest  <= rob_pop_data.dest;
	commit.value <= rob_head_value;
end

endmodule

//--- rtl/ooo_core.sv
`timescale 1ns/1ps

module ooo_core import cpu_pkg::*; #(
	parameter int ROB_DEPTH = 8,
	parameter int RS_DEPTH  = 4
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    instr_valid,
	input  instr_t  instr,
	output logic    instr_ready,
	output commit_t commit
);

// register file and status
logic                   reg_we;
reg_addr_t              reg_waddr;
uint32_t                reg_wdata;
reg_addr_t        [3:0] reg_raddr;
uint32_t          [3:0] reg_rdata;
register_status_t [3:0] reg_status;
logic                   status_we;
reg_addr_t              status_waddr;
register_status_t       status_wdata;
logic                   commit_wrst;
rob_index_t             commit_tag;

// ROB
logic             rob_push, rob_pop, rob_full;
logic             rob_head_valid, rob_head_done;
rob_packet_t      rob_push_data, rob_pop_data;
rob_index_t       rob_reorder, rob_head_tag;
uint32_t          rob_head_value;
rob_index_t [1:0] rob_raddr;
logic       [1:0] rob_rdata_valid;
uint32_t    [1:0] rob_rdata;

// reservation station and CDB
logic        rs_push, rs_full;
rs_entry_t   rs_in;
cdb_packet_t cdb;

regfile regfile_inst(
	.clk,
	.rst_n,
	.we    ( reg_we    ),
	.waddr ( reg_waddr ),
	.wdata ( reg_wdata ),
	.raddr ( reg_raddr ),
	.rdata ( reg_rdata )
);

regfile_status regfile_status_inst(
	.clk,
	.rst_n,
	.we       ( status_we    ),
	.waddr    ( status_waddr ),
	.wdata    ( status_wdata ),
	.wrst     ( commit_wrst  ),
	.wreorder ( commit_tag   ),
	.raddr    ( reg_raddr    ),
	.rdata    ( reg_status   )
);

rob #(
	.ROB_DEPTH ( ROB_DEPTH )
) rob_inst (
	.clk,
	.rst_n,
	.push       ( rob_push       ),
	.data_i     ( rob_push_data  ),
	.reorder    ( rob_reorder    ),
	.full       ( rob_full       ),
	.pop        ( rob_pop        ),
	.head_valid ( rob_head_valid ),
	.head_done  ( rob_head_done  ),
	.head_tag   ( rob_head_tag   ),
	.data_o     ( rob_pop_data   ),
	.head_value ( rob_head_value ),
	.cdb,
	.rob_raddr,
	.rob_rdata_valid,
	.rob_rdata
);

instr_issue instr_issue_inst(
	.instr_valid,
	.instr,
	.instr_ready,
	.rob_full,
	.rob_reorder,
	.rob_push,
	.rob_push_data,
	.rs_full,
	.rs_push,
	.rs_in,
	.reg_raddr,
	.reg_rdata,
	.reg_status,
	.status_we,
	.status_waddr,
	.status_wdata,
	.rob_raddr,
	.rob_rdata_valid,
	.rob_rdata,
	.cdb
);

alu_exec #(
	.RS_DEPTH ( RS_DEPTH )
) alu_exec_inst (
	.clk,
	.rst_n,
	.rs_push,
	.rs_in,
	.rs_full,
	.cdb
);

instr_commit instr_commit_inst(
	.clk,
	.rst_n,
	.rob_head_valid,
	.rob_head_done,
	.rob_head_tag,
	.rob_pop_data,
	.rob_head_value,
	.rob_pop,
	.reg_we,
	.reg_waddr,
	.reg_wdata,
	.commit_wrst,
	.commit_tag,
	.commit
);

endmodule

//--- verif/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core import cpu_pkg::*; ();

localparam int MAX_LINES = 64;
localparam int BURST_FIRST = 20;
localparam int BURST_LAST = 31;

logic    clk = 1'b0;
logic    rst_n = 1'b0;
logic    instr_valid = 1'b0;
instr_t  instr = '0;
logic    instr_ready;
commit_t commit;

// Three words per line for instruction, destination and value
logic [31:0] stim [3*MAX_LINES];
int          num_lines = 0;
int          issue_idx = 0;
int          commit_count = 0;
int          cycle_count = 0;
logic        stall_seen = 1'b0;
logic        reset_released = 1'b0;
logic [15:0] lfsr = 16'd37935;

ooo_core #(
	.ROB_DEPTH ( 8 ),
	.RS_DEPTH  ( 4 )
) DUT (
	.clk,
	.rst_n,
	.instr_valid,
	.instr,
	.instr_ready,
	.commit
);

always #5 clk = ~clk;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [31:0] fill_word(input int addr);
	return 32'hfee0_0000 ^ 32'(addr);
endfunction

function automatic logic in_burst(input int idx);
	return idx >= BURST_FIRST && idx <= BURST_LAST;
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
		$display("SOME TESTS FAILED");
		$fatal(1, "Mismatch on %s", name);
	end
endtask

// Driver holds the word until it is accepted
always @(posedge clk) begin
	int   next_idx;
	logic gap;
	if (!rst_n) begin
		instr_valid <= 1'b0;
		issue_idx   <= 0;
	end else begin
		next_idx = issue_idx;
		if (instr_valid && instr_ready) begin
			next_idx = issue_idx + 1;
		end
		issue_idx <= next_idx;
		if (instr_valid && !instr_ready) begin
			instr_valid <= 1'b1;
		end else if (next_idx >= num_lines) begin
			instr_valid <= 1'b0;
		end else begin
			lfsr = lfsr_next(lfsr);
			gap  = lfsr[0];
			lfsr = lfsr_next(lfsr);
			gap  = gap & lfsr[0];
			if (gap && !in_burst(next_idx)) begin
				instr_valid <= 1'b0;
			end else begin
				instr_valid <= 1'b1;
				instr       <= stim[3*next_idx];
			end
		end
	end
end

// Reset state and in-order commit checker
always @(negedge clk) begin
	if (!rst_n || !reset_released) begin
		check_value("commit.valid", 32'(commit.valid), 32'd0);
		check_value("instr_ready", 32'(instr_ready), 32'd1);
		reset_released = rst_n;
	end else begin
		if (!instr_ready && in_burst(issue_idx)) begin
			stall_seen = 1'b1;
		end
		if (commit.valid) begin
			if (commit_count >= num_lines) begin
				$display("Error: more instructions committed than the stimulus holds");
				$display("SOME TESTS FAILED");
				$fatal(1, "Extra commit");
			end else begin
				check_value("commit.dest", 32'(commit.dest), stim[3*commit_count+1]);
				check_value("commit.value", commit.value, stim[3*commit_count+2]);
				commit_count++;
			end
		end
	end
end

always @(posedge clk) begin
	cycle_count <= cycle_count + 1;
	if (cycle_count >= num_lines * 20 + 100) begin
		$display("Timeout: only %0d of %0d instructions committed after %0d cycles",
			commit_count, num_lines, cycle_count);
		$display("SOME TESTS FAILED");
		$fatal(1, "Timeout");
	end
end

initial begin
	for (int i = 0; i < 3*MAX_LINES; i++) begin
		stim[i] = fill_word(i);
	end
	$readmemh("verif/core_stimulus.txt", stim);
	while (num_lines < MAX_LINES && stim[3*num_lines] != fill_word(3*num_lines)) begin
		num_lines++;
	end
	$display("Loaded %0d instructions", num_lines);
	repeat (3) @(posedge clk);
	rst_n <= 1'b1;
	wait (commit_count == num_lines);
	// Drain window to catch duplicate commits
	repeat (10) @(posedge clk);
	check_value("accepted instructions", 32'(issue_idx), 32'(num_lines));
	check_value("instr_ready low during burst", 32'(stall_seen), 32'd1);
	$display("ALL TESTS PASSED");
	$finish;
end

endmodule

//--- verif/core_stimulus.txt
// Columns: instruction word, expected destination register, expected commit value (hex)
// Lines 21 to 32 are driven back to back without gaps
3c011234 01 12340000
34028765 02 00008765
2403fff6 03 fffffff6
24040005 04 00000005
00222821 05 12348765
00833023 06 0000000f
00253824 07 12340000
00434025 08 fffffff7
00224826 09 12348765
0064502a 0a 00000001
0083582a 0b 00000000
0062602a 0c 00000001
240d0001 0d 00000001
25ad0002 0d 00000003
340d0100 0d 00000100
01ad7021 0e 00000200
00220021 00 12348765
24800007 00 0000000c
000d7821 0f 00000100
00008025 10 00000000
24110001 11 00000001
02318821 11 00000002
02318821 11 00000004
02318821 11 00000008
02318821 11 00000010
2632ffff 12 0000000f
02519823 13 ffffffff
0260a02a 14 00000001
0272a826 15 fffffff0
02a5b024 16 12348760
02d48821 11 12348761
3637000e 17 1234876f
01a0c021 18 00000100
0222c823 19 1233fffc

//--- files.f
rtl/cpu_pkg.sv
rtl/regfile.sv
rtl/regfile_status.sv
rtl/rob.sv
rtl/instr_issue.sv
rtl/alu_exec.sv
rtl/instr_commit.sv
rtl/ooo_core.sv
verif/tb_ooo_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_ooo_core -f files.f -o sim_ooo_core
./obj_dir/sim_ooo_core 2>&1 | tee sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
